/* lsq_defs.svh */
// Sizing constants for the load/store queue
// Included by the package and by every module that sizes storage
// Changing a width here changes the matching package typedef

`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

////////////////////////////////////////
// Queue depths
////////////////////////////////////////

`define LSQ_LQ_DEPTH 8	// Load queue entries, power of two
`define LSQ_SQ_DEPTH 8	// Store queue entries, power of two

////////////////////////////////////////
// Field widths
////////////////////////////////////////

// Reorder buffer index, 32 entries
`define LSQ_ROB_IDX_W 5

`define LSQ_PRF_TAG_W 6	// Physical register tag

// Cache transaction tag, value zero means none
`define LSQ_MEM_TAG_W 4

`define LSQ_DATA_W 64	// Data and address word

`endif

/* verilog/lsq_pkg.sv */
// Shared types for the load/store queue
// Imported by every RTL module and by the testbench

`default_nettype none

`include "lsq_defs.svh"

package lsq_pkg;

	// Plain vectors with a meaning
	typedef logic [`LSQ_DATA_W-1:0] data_t;
	typedef logic [`LSQ_PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [`LSQ_ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [`LSQ_MEM_TAG_W-1:0] mem_tag_t;
	typedef logic [$clog2(`LSQ_LQ_DEPTH)-1:0] lq_idx_t;	// Load queue slot
	typedef logic [$clog2(`LSQ_SQ_DEPTH)-1:0] sq_idx_t;	// Store queue slot

	typedef enum logic [1:0] {OP_NONE, OP_LOAD, OP_STORE} lsq_op_e;
	typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_command_e;

	////////////////////////////////////////
	// Bundles
	////////////////////////////////////////

	typedef struct packed {
		lsq_op_e op;	// OP_NONE when nothing dispatched
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;	// Load destination
		data_t base;
		data_t offset;	// Immediate, address is base plus offset
		data_t store_data;
		logic store_data_ready;	// Low means wait for store_data_tag on CDB
		prf_tag_t store_data_tag;
	} dispatch_t;

	typedef struct packed {
		logic valid;
		prf_tag_t tag;
		data_t data;
	} cdb_t;

	// Load writeback toward the CDB
	typedef struct packed {
		logic valid;
		prf_tag_t dest_tag;
		rob_idx_t rob_idx;
		data_t data;
	} lsq_result_t;

	typedef struct packed {
		bus_command_e command;
		data_t addr;
		data_t data;	// Store data only
	} mem_req_t;

	// Request offered by one queue
	typedef struct packed {
		logic valid;
		rob_idx_t rob_idx;	// Meaningful for stores only
		data_t addr;
		data_t data;
	} issue_cand_t;

	typedef struct packed {
		logic valid;
		lq_idx_t lq_idx;
		data_t data;
	} lq_fill_t;

	// Distance of an index from the ROB head, wraps at ROB size
	function automatic rob_idx_t rob_age(input rob_idx_t idx, input rob_idx_t head);
		return rob_idx_t'(idx - head);
	endfunction

endpackage

`default_nettype wire

/* verilog/load_queue.sv */
// Circular queue of loads
// Loads enter at the tail, issue in order from the issue pointer and
// retire from the head onto the result port once their data is back

`timescale 1ns/1ns
`default_nettype none

`include "lsq_defs.svh"

module load_queue import lsq_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input dispatch_t dispatch,
	input wire logic mispredict,
	input rob_idx_t rob_head,
	input wire logic older_store_valid,	// A store is still waiting
	input rob_idx_t older_store_rob_idx,	// Its ROB index
	input wire logic load_accepted,
	input lq_fill_t fill,
	output issue_cand_t load_cand,
	output lq_idx_t issue_slot,
	output lsq_result_t result,
	output logic lq_full
);

	localparam int IDX_W = $clog2(`LSQ_LQ_DEPTH);

	// Pointers carry one extra wrap bit
	logic [IDX_W:0] head_ptr, issue_ptr, tail_ptr;
	lq_idx_t head_slot, tail_slot;

	data_t lq_addr [`LSQ_LQ_DEPTH];
	rob_idx_t lq_rob [`LSQ_LQ_DEPTH];
	prf_tag_t lq_dest [`LSQ_LQ_DEPTH];
	data_t lq_data [`LSQ_LQ_DEPTH];
	logic [`LSQ_LQ_DEPTH-1:0] lq_done;	// Fill data has arrived

	logic enqueue;
	logic retire;
	logic older_than_store;

	assign head_slot = head_ptr[IDX_W-1:0];
	assign tail_slot = tail_ptr[IDX_W-1:0];
	assign issue_slot = issue_ptr[IDX_W-1:0];

	// Same slot, opposite lap
	assign lq_full = (head_ptr[IDX_W] != tail_ptr[IDX_W]) &&
		(head_ptr[IDX_W-1:0] == tail_ptr[IDX_W-1:0]);

	assign enqueue = (dispatch.op == OP_LOAD) && !lq_full;
	assign retire = (head_ptr != issue_ptr) && lq_done[head_slot];	// Head issued and filled

	////////////////////////////////////////
	// Issue candidate
	////////////////////////////////////////

	// Compare ages relative to the ROB head
	assign older_than_store =
		rob_age(lq_rob[issue_slot], rob_head) < rob_age(older_store_rob_idx, rob_head);

	always_comb begin
		load_cand.valid = (issue_ptr != tail_ptr) && (!older_store_valid || older_than_store);
		load_cand.rob_idx = '0;	// Loads do not need it
		load_cand.addr = lq_addr[issue_slot];
		load_cand.data = '0;
	end

	////////////////////////////////////////
	// Pointers and fill flags
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin	// Flush empties the queue
			head_ptr <= '0;
			issue_ptr <= '0;
			tail_ptr <= '0;
			lq_done <= '0;
		end else begin
			if (enqueue) tail_ptr <= tail_ptr + 1'b1;
			if (load_accepted) issue_ptr <= issue_ptr + 1'b1;
			if (retire) head_ptr <= head_ptr + 1'b1;
			if (fill.valid) lq_done[fill.lq_idx] <= 1'b1;
			if (retire) lq_done[head_slot] <= 1'b0;	// Slot free again
			if (enqueue) lq_done[tail_slot] <= 1'b0;
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		if (enqueue) begin
			lq_addr[tail_slot] <= dispatch.base + dispatch.offset;
			lq_rob[tail_slot] <= dispatch.rob_idx;
			lq_dest[tail_slot] <= dispatch.dest_tag;
		end
		if (fill.valid) lq_data[fill.lq_idx] <= fill.data;
	end

	////////////////////////////////////////
	// In-order writeback
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= retire;	// One cycle per load
		end
		result.dest_tag <= lq_dest[head_slot];
		result.rob_idx <= lq_rob[head_slot];
		result.data <= lq_data[head_slot];
	end

endmodule

`default_nettype wire

/* verilog/store_queue.sv */
// Circular queue of stores
// Pending store data is captured from the CDB by tag; the head store is
// offered to the cache once its data is ready and it heads the ROB

`timescale 1ns/1ns
`default_nettype none

`include "lsq_defs.svh"

module store_queue import lsq_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input dispatch_t dispatch,
	input wire logic mispredict,
	input cdb_t cdb,
	input rob_idx_t rob_head,
	input wire logic store_accepted,
	output issue_cand_t store_cand,
	output logic older_store_valid,
	output rob_idx_t older_store_rob_idx,
	output logic sq_full
);

	localparam int IDX_W = $clog2(`LSQ_SQ_DEPTH);

	logic [IDX_W:0] head_ptr, tail_ptr;	// Extra bit tells full from empty
	sq_idx_t head_slot, tail_slot;

	data_t sq_addr [`LSQ_SQ_DEPTH];
	data_t sq_data [`LSQ_SQ_DEPTH];
	rob_idx_t sq_rob [`LSQ_SQ_DEPTH];
	prf_tag_t sq_tag [`LSQ_SQ_DEPTH];	// Producer of pending data
	logic [`LSQ_SQ_DEPTH-1:0] sq_ready;

	logic [`LSQ_SQ_DEPTH-1:0] cdb_hit;
	logic enqueue;
	logic enq_cdb_hit;	// Data broadcast in the dispatch cycle itself
	logic not_empty;

	assign head_slot = head_ptr[IDX_W-1:0];
	assign tail_slot = tail_ptr[IDX_W-1:0];
	assign not_empty = head_ptr != tail_ptr;

	assign sq_full = (head_ptr[IDX_W] != tail_ptr[IDX_W]) &&
		(head_ptr[IDX_W-1:0] == tail_ptr[IDX_W-1:0]);

	assign enqueue = (dispatch.op == OP_STORE) && !sq_full;
	assign enq_cdb_hit = !dispatch.store_data_ready && cdb.valid &&
		(cdb.tag == dispatch.store_data_tag);

	////////////////////////////////////////
	// CDB snoop
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
			cdb_hit[i] = cdb.valid && !sq_ready[i] && (cdb.tag == sq_tag[i]);
		end
	end

	// Oldest waiting store, seen by the load queue
	assign older_store_valid = not_empty;
	assign older_store_rob_idx = sq_rob[head_slot];

	always_comb begin
		store_cand.valid = not_empty && sq_ready[head_slot] &&
			(rob_age(sq_rob[head_slot], rob_head) == '0);	// Store is at ROB head
		store_cand.rob_idx = sq_rob[head_slot];
		store_cand.addr = sq_addr[head_slot];
		store_cand.data = sq_data[head_slot];
	end

	////////////////////////////////////////
	// Pointers and ready bits
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			sq_ready <= '0;
		end else begin
			for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
				if (cdb_hit[i]) sq_ready[i] <= 1'b1;
			end
			if (enqueue) sq_ready[tail_slot] <= dispatch.store_data_ready || enq_cdb_hit;
			if (store_accepted) head_ptr <= head_ptr + 1'b1;	// Leaves on acceptance
			if (enqueue) tail_ptr <= tail_ptr + 1'b1;
		end
	end

	// Entry payload, enqueue overrides a stale snoop on the tail slot
	always_ff @(posedge clock) begin
		for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
			if (cdb_hit[i]) sq_data[i] <= cdb.data;
		end
		if (enqueue) begin
			sq_addr[tail_slot] <= dispatch.base + dispatch.offset;
			sq_rob[tail_slot] <= dispatch.rob_idx;
			sq_tag[tail_slot] <= dispatch.store_data_tag;
			sq_data[tail_slot] <= enq_cdb_hit ? cdb.data : dispatch.store_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/mem_issue.sv */
// Cache request arbiter
// Picks the store candidate over the load candidate, drives the request
// and turns a nonzero response tag into acceptance pulses

`timescale 1ns/1ns
`default_nettype none

module mem_issue import lsq_pkg::*; (
	input issue_cand_t load_cand,
	input issue_cand_t store_cand,
	input lq_idx_t issue_slot,	// Slot of the load candidate
	input mem_tag_t mem_response,	// Zero means refused
	output mem_req_t mem_req,
	output logic load_accepted,
	output logic store_accepted,
	output logic record_valid,
	output mem_tag_t record_tag,
	output lq_idx_t record_slot
);

	logic store_sel;
	logic load_sel;
	logic accepted;

	assign store_sel = store_cand.valid;	// Store wins
	assign load_sel = load_cand.valid && !store_cand.valid;
	assign accepted = mem_response != '0;

	////////////////////////////////////////
	// Request
	////////////////////////////////////////

	always_comb begin
		mem_req.command = BUS_NONE;
		mem_req.addr = '0;
		mem_req.data = '0;
		if (store_sel) begin
			mem_req.command = BUS_STORE;
			mem_req.addr = store_cand.addr;
			mem_req.data = store_cand.data;
		end else if (load_sel) begin
			mem_req.command = BUS_LOAD;
			mem_req.addr = load_cand.addr;
		end
	end

	// Refused requests stay put since queue state does not move
	assign store_accepted = store_sel && accepted;
	assign load_accepted = load_sel && accepted;

	// Accepted load goes to the tag table
	assign record_valid = load_accepted;
	assign record_tag = mem_response;
	assign record_slot = issue_slot;

endmodule

`default_nettype wire

/* verilog/mem_tag_table.sv */
// Outstanding load tag table
// Maps each cache tag to the load slot that owns it and turns returning
// data into a fill; a mispredict forgets every tag

`timescale 1ns/1ns
`default_nettype none

`include "lsq_defs.svh"

module mem_tag_table import lsq_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic mispredict,
	input wire logic record_valid,
	input mem_tag_t record_tag,
	input lq_idx_t record_slot,
	input mem_tag_t mem_tag,	// Nonzero marks returning data
	input data_t mem_data,
	output lq_fill_t fill
);

	localparam int NUM_TAGS = 1 << `LSQ_MEM_TAG_W;

	logic [NUM_TAGS-1:0] tag_valid;
	lq_idx_t tag_slot [NUM_TAGS];

	// Late data on a forgotten tag is dropped here
	assign fill.valid = (mem_tag != '0) && tag_valid[mem_tag];
	assign fill.lq_idx = tag_slot[mem_tag];
	assign fill.data = mem_data;

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			tag_valid <= '0;
		end else begin
			if (mem_tag != '0) tag_valid[mem_tag] <= 1'b0;	// Transaction done
			if (record_valid) tag_valid[record_tag] <= 1'b1;
		end
		if (record_valid) tag_slot[record_tag] <= record_slot;
	end

endmodule

`default_nettype wire

/* verilog/lsq_top.sv */
// Load/store queue top level
// Connects the two queues, the request arbiter and the tag table;
// lsq_full tells dispatch to stall

`timescale 1ns/1ns
`default_nettype none

module lsq_top import lsq_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input dispatch_t dispatch,
	input cdb_t cdb,
	input rob_idx_t rob_head,
	input wire logic mispredict,
	input mem_tag_t mem_response,	// Same-cycle answer to mem_req
	input mem_tag_t mem_tag,
	input data_t mem_data,
	output mem_req_t mem_req,
	output lsq_result_t result,
	output logic lsq_full
);

	issue_cand_t load_cand, store_cand;
	lq_idx_t issue_slot;
	logic load_accepted, store_accepted;
	logic record_valid;
	mem_tag_t record_tag;
	lq_idx_t record_slot;
	lq_fill_t fill;
	logic older_store_valid;
	rob_idx_t older_store_rob_idx;
	logic lq_full, sq_full;

	////////////////////////////////////////
	// Queues
	////////////////////////////////////////

	load_queue u_load_queue (
		.clock(clock),
		.reset(reset),
		.dispatch(dispatch),
		.mispredict(mispredict),
		.rob_head(rob_head),
		.older_store_valid(older_store_valid),
		.older_store_rob_idx(older_store_rob_idx),
		.load_accepted(load_accepted),
		.fill(fill),
		.load_cand(load_cand),
		.issue_slot(issue_slot),
		.result(result),
		.lq_full(lq_full)
	);

	store_queue u_store_queue (
		.clock(clock),
		.reset(reset),
		.dispatch(dispatch),
		.mispredict(mispredict),
		.cdb(cdb),
		.rob_head(rob_head),
		.store_accepted(store_accepted),
		.store_cand(store_cand),
		.older_store_valid(older_store_valid),
		.older_store_rob_idx(older_store_rob_idx),
		.sq_full(sq_full)
	);

	assign lsq_full = lq_full || sq_full;	// Either queue stalls dispatch

	////////////////////////////////////////
	// Cache side
	////////////////////////////////////////

	mem_issue u_mem_issue (
		.load_cand(load_cand),
		.store_cand(store_cand),
		.issue_slot(issue_slot),
		.mem_response(mem_response),
		.mem_req(mem_req),
		.load_accepted(load_accepted),
		.store_accepted(store_accepted),
		.record_valid(record_valid),
		.record_tag(record_tag),
		.record_slot(record_slot)
	);

	mem_tag_table u_mem_tag_table (
		.clock(clock),
		.reset(reset),
		.mispredict(mispredict),
		.record_valid(record_valid),
		.record_tag(record_tag),
		.record_slot(record_slot),
		.mem_tag(mem_tag),
		.mem_data(mem_data),
		.fill(fill)
	);

endmodule

`default_nettype wire

/* bench/lsq_properties.sv */
// Concurrent checks on the load/store queue, bound into lsq_top
// Covers dispatch stall, refused request hold and flush behavior

`timescale 1ns/1ns
`default_nettype none

module lsq_properties import lsq_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input dispatch_t dispatch,
	input wire logic lsq_full,
	input mem_req_t mem_req,
	input mem_tag_t mem_response,
	input wire logic mispredict,
	input wire logic older_store_valid,	// Store queue not empty
	input wire logic load_valid,	// Load candidate offered
	input wire logic [15:0] tag_valid
);

	int failures = 0;	// Failed assertion count

	// Driver must stall while full
	a_no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
		lsq_full |-> dispatch.op == OP_NONE)
		else begin
			$error("Dispatch while lsq_full is high");
			failures++;
		end

	a_store_repeat: assert property (@(posedge clock) disable iff (reset)
		(mem_req.command == BUS_STORE && mem_response == '0 && !mispredict) |=> $stable(mem_req))
		else begin
			$error("Refused store request changed");
			failures++;
		end

	// A refused load holds unless a store takes priority
	a_load_repeat: assert property (@(posedge clock) disable iff (reset)
		(mem_req.command == BUS_LOAD && mem_response == '0 && !mispredict) |=>
		($stable(mem_req) || mem_req.command == BUS_STORE))
		else begin
			$error("Refused load request changed");
			failures++;
		end

	a_flush_empty: assert property (@(posedge clock) disable iff (reset)
		mispredict |=> (!lsq_full && !older_store_valid && !load_valid && tag_valid == '0))
		else begin
			$error("Queues or tag table not empty after mispredict");
			failures++;
		end

endmodule

bind lsq_top lsq_properties u_lsq_properties (
	.clock(clock),
	.reset(reset),
	.dispatch(dispatch),
	.lsq_full(lsq_full),
	.mem_req(mem_req),
	.mem_response(mem_response),
	.mispredict(mispredict),
	.older_store_valid(older_store_valid),
	.load_valid(load_cand.valid),
	.tag_valid(u_mem_tag_table.tag_valid)
);

`default_nettype wire

/* bench/lsq_tb.sv */
// Testbench for the load/store queue
// Applies a table of dispatches, models a non-blocking cache that refuses at random
// and returns load data late, then checks requests and in-order load results

`timescale 1ns/1ns
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

	localparam int NROWS = 19;
	localparam int FLUSH_START = 11;	// First row of the flush phase
	localparam int WAIT_LIMIT = 2000;

	typedef struct packed {
		lsq_op_e op;
		rob_idx_t rob;
		prf_tag_t dest;
		data_t base;
		data_t offset;
		data_t sdata;	// Store data, or the value later broadcast on the CDB
		logic sready;
		prf_tag_t stag;
		logic [7:0] cdb_delay;	// Cycles from dispatch to CDB broadcast
		logic flush;	// Mispredict once this row sits in the queue
	} row_t;

	logic clock;
	logic reset;
	dispatch_t dispatch;
	cdb_t cdb;
	rob_idx_t rob_head;
	logic mispredict;
	mem_tag_t mem_response;
	mem_tag_t mem_tag;
	data_t mem_data;
	mem_req_t mem_req;
	lsq_result_t result;
	logic lsq_full;

	row_t rows [NROWS];
	int seed = 32'h7817;
	int errors = 0;
	int timeouts = 0;
	int cycle = 0;
	string current_test = "reset";
	logic accept_roll;
	logic slow_cache;
	logic [15:0] tag_busy;
	rob_idx_t next_rob;
	bit done_flag [NROWS];
	bit cdb_sent [NROWS];

	// Bookkeeping by row number, in program order
	int rob_q[$], load_issue_q[$], result_q[$], store_q[$], cdb_q[$], cdb_due[$];
	mem_tag_t ret_tag[$];
	data_t ret_addr[$];
	int ret_due[$];

	lsq_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic mem_tag_t lowest_free(input logic [15:0] busy);
		for (int t = 1; t < 16; t++) begin
			if (!busy[t]) return mem_tag_t'(t);
		end
		return '0;	// No tag left, so the cache refuses
	endfunction

	// Same-cycle cache answer
	assign mem_response = (mem_req.command != BUS_NONE && accept_roll) ? lowest_free(tag_busy) : '0;

	task automatic check_value(input string what, input data_t expected, input data_t actual);
		assert (expected == actual) else begin
			$display("FAIL %s %s: expected %h, actual %h", current_test, what, expected, actual);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Cache model and monitor
	////////////////////////////////////////

	always @(posedge clock) begin
		int s;
		int k;
		cycle++;
		if (reset) begin
			mem_tag <= '0;
			cdb <= '0;
			accept_roll <= 1'b0;
		end else begin
			if (mem_req.command == BUS_LOAD) begin
				assert (load_issue_q.size() > 0) else begin
					$display("Load request seen with no load waiting to issue");
					errors++;
				end
				if (load_issue_q.size() > 0) begin
					s = load_issue_q[0];
					check_value("load addr", rows[s].base + rows[s].offset, mem_req.addr);
					assert (store_q.size() == 0 || store_q[0] > s) else begin
						$display("Load at row %0d issued ahead of an older store", s);
						errors++;
					end
					if (mem_response != '0) begin	// Accepted, data comes back later
						ret_tag.push_back(mem_response);
						ret_addr.push_back(mem_req.addr);
						ret_due.push_back(cycle + 1 + ($random(seed) & 7) + (slow_cache ? 40 : 0));
						tag_busy[mem_response] <= 1'b1;
						void'(load_issue_q.pop_front());
					end
				end
			end else if (mem_req.command == BUS_STORE) begin
				assert (store_q.size() > 0) else begin
					$display("Store request seen with no store waiting");
					errors++;
				end
				if (store_q.size() > 0) begin
					s = store_q[0];
					check_value("store addr", rows[s].base + rows[s].offset, mem_req.addr);
					check_value("store data", rows[s].sdata, mem_req.data);
					assert (rows[s].sready || cdb_sent[s]) else begin
						$display("Store at row %0d issued before its data was on the CDB", s);
						errors++;
					end
					assert (rob_q.size() > 0 && rob_q[0] == s) else begin
						$display("Store at row %0d issued before reaching the ROB head", s);
						errors++;
					end
					if (mem_response != '0) begin
						done_flag[s] = 1'b1;
						void'(store_q.pop_front());
					end
				end
			end

			// Load results in program order
			if (result.valid) begin
				assert (result_q.size() > 0) else begin
					$display("Unexpected load result with rob index %0d", result.rob_idx);
					errors++;
				end
				if (result_q.size() > 0) begin
					s = result_q.pop_front();
					check_value("dest_tag", data_t'(rows[s].dest), data_t'(result.dest_tag));
					check_value("rob_idx", data_t'(rows[s].rob), data_t'(result.rob_idx));
					check_value("data", (rows[s].base + rows[s].offset) ^ 64'hA5A5, result.data);
					done_flag[s] = 1'b1;
				end
			end

			// One data return per cycle, whichever is due first
			mem_tag <= '0;
			k = -1;
			for (int j = 0; j < ret_due.size(); j++) begin
				if (k < 0 && ret_due[j] <= cycle) k = j;
			end
			if (k >= 0) begin
				mem_tag <= ret_tag[k];
				mem_data <= ret_addr[k] ^ 64'hA5A5;
				tag_busy[ret_tag[k]] <= 1'b0;
				ret_tag.delete(k);
				ret_addr.delete(k);
				ret_due.delete(k);
			end

			// CDB broadcasts for pending store data
			cdb <= '0;
			if (cdb_q.size() > 0 && cdb_due[0] <= cycle) begin
				s = cdb_q.pop_front();
				void'(cdb_due.pop_front());
				cdb <= '{valid: 1'b1, tag: rows[s].stag, data: rows[s].sdata};
				cdb_sent[s] = 1'b1;
			end

			if (mispredict) begin	// Flushed work expects nothing more
				rob_q.delete();
				load_issue_q.delete();
				result_q.delete();
				store_q.delete();
				cdb_q.delete();
				cdb_due.delete();
			end

			// In-order commit
			while (rob_q.size() > 0 && done_flag[rob_q[0]]) void'(rob_q.pop_front());
			rob_head <= (rob_q.size() > 0) ? rows[rob_q[0]].rob : next_rob;
			accept_roll <= ($random(seed) & 3) != 0;	// Refuse about one in four
		end
	end

	task automatic dispatch_row(input int i, output bit ok);
		ok = 1'b0;
		for (int t = 0; t < WAIT_LIMIT; t++) begin
			@(posedge clock);
			if (!lsq_full) begin
				ok = 1'b1;
				break;
			end
		end
		if (ok) begin
			// Pending stores carry a wrong value until the CDB delivers the real one
			dispatch <= '{op: rows[i].op, rob_idx: rows[i].rob, dest_tag: rows[i].dest,
				base: rows[i].base, offset: rows[i].offset,
				store_data: rows[i].sready ? rows[i].sdata : ~rows[i].sdata,
				store_data_ready: rows[i].sready, store_data_tag: rows[i].stag};
			rob_q.push_back(i);
			next_rob = rows[i].rob + 1'b1;
			if (rows[i].op == OP_LOAD) begin
				load_issue_q.push_back(i);
				result_q.push_back(i);
			end else begin
				store_q.push_back(i);
				if (!rows[i].sready) begin
					cdb_q.push_back(i);
					cdb_due.push_back(cycle + rows[i].cdb_delay);
				end
			end
			@(posedge clock);
			dispatch <= '0;	// Gap so lsq_full is current at the next check
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		bit ok;
		reset = 1'b1;
		dispatch = '0;
		cdb = '0;
		rob_head = '0;
		mispredict = 1'b0;
		mem_tag = '0;
		mem_data = '0;
		accept_roll = 1'b0;
		slow_cache = 1'b0;
		tag_busy = '0;
		next_rob = '0;
		rows[0] = '{OP_LOAD, 5'd0, 6'd1, 64'h1000, 64'h8, '0, 1'b1, '0, 8'd0, 1'b0};
		rows[1] = '{OP_LOAD, 5'd1, 6'd2, 64'h2000, 64'h10, '0, 1'b1, '0, 8'd0, 1'b0};
		rows[2] = '{OP_LOAD, 5'd2, 6'd3, 64'h3000, 64'h20, '0, 1'b1, '0, 8'd0, 1'b0};
		rows[3] = '{OP_LOAD, 5'd3, 6'd4, 64'h4000, 64'h30, '0, 1'b1, '0, 8'd0, 1'b0};
		rows[4] = '{OP_STORE, 5'd4, 6'd0, 64'h5000, 64'h8, 64'hDEAD_BEEF, 1'b0, 6'd10, 8'd6, 1'b0};
		rows[5] = '{OP_LOAD, 5'd5, 6'd5, 64'h5000, 64'h40, '0, 1'b1, '0, 8'd0, 1'b0};
		rows[6] = '{OP_STORE, 5'd6, 6'd0, 64'h6000, 64'h0, 64'h1234, 1'b1, '0, 8'd0, 1'b0};
		rows[7] = '{OP_LOAD, 5'd7, 6'd6, 64'h6100, 64'h8, '0, 1'b1, '0, 8'd0, 1'b0};
		rows[8] = '{OP_LOAD, 5'd8, 6'd7, 64'h7000, 64'h18, '0, 1'b1, '0, 8'd0, 1'b0};
		rows[9] = '{OP_STORE, 5'd9, 6'd0, 64'h7100, 64'h10, 64'hCAFE, 1'b0, 6'd11, 8'd3, 1'b0};
		rows[10] = '{OP_LOAD, 5'd10, 6'd8, 64'h7200, 64'h8, '0, 1'b1, '0, 8'd0, 1'b0};
		for (int i = FLUSH_START; i < NROWS; i++) begin	// Eight loads to fill the queue
			rows[i] = '{OP_LOAD, rob_idx_t'(i), prf_tag_t'(i - 2), 64'h8000 + i * 64'h100,
				64'h4, '0, 1'b1, '0, 8'd0, i == NROWS - 1};
		end

		begin : test_body
			repeat (16) @(posedge clock);
			reset <= 1'b0;
			@(posedge clock);
			@(posedge clock);
			check_value("result.valid", '0, data_t'(result.valid));
			check_value("lsq_full", '0, data_t'(lsq_full));
			check_value("command", data_t'(BUS_NONE), data_t'(mem_req.command));

			for (int i = 0; i < NROWS; i++) begin
				if (i == 0) current_test = "loads";
				if (i == 4) current_test = "stores";
				if (i == FLUSH_START) begin
					current_test = "flush";
					ok = 1'b0;
					for (int t = 0; t < WAIT_LIMIT; t++) begin	// Drain earlier work
						@(posedge clock);
						if (rob_q.size() == 0 && ret_tag.size() == 0) begin
							ok = 1'b1;
							break;
						end
					end
					if (!ok) begin
						$display("Timeout waiting for the queues to drain");
						timeouts++;
						disable test_body;
					end
					slow_cache = 1'b1;
				end
				dispatch_row(i, ok);
				if (!ok) begin
					$display("Timeout waiting for lsq_full to fall before row %0d", i);
					timeouts++;
					disable test_body;
				end
				if (rows[i].flush) begin
					@(posedge clock);
					check_value("lsq_full before flush", 64'd1, data_t'(lsq_full));
					mispredict <= 1'b1;
					@(posedge clock);
					mispredict <= 1'b0;
					@(posedge clock);
					check_value("lsq_full after flush", '0, data_t'(lsq_full));
				end
			end

			// Late data of flushed loads must not produce results
			ok = 1'b0;
			for (int t = 0; t < WAIT_LIMIT; t++) begin
				@(posedge clock);
				if (ret_tag.size() == 0) begin
					ok = 1'b1;
					break;
				end
			end
			if (!ok) begin
				$display("Timeout waiting for stale load data to return");
				timeouts++;
				disable test_body;
			end
			repeat (4) @(posedge clock);
		end

		errors += DUT.u_lsq_properties.failures;	// Bound assertion failures
		$display("Errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
verilog/lsq_pkg.sv
verilog/load_queue.sv
verilog/store_queue.sv
verilog/mem_issue.sv
verilog/mem_tag_table.sv
verilog/lsq_top.sv
bench/lsq_properties.sv
bench/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - include_dirs:
      - .
    files:
      - verilog/lsq_pkg.sv
      - verilog/load_queue.sv
      - verilog/store_queue.sv
      - verilog/mem_issue.sv
      - verilog/mem_tag_table.sv
      - verilog/lsq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bench/lsq_properties.sv
      - bench/lsq_tb.sv
